//--- rom_load_top.f
+incdir+include
logic/rom_pkg.sv
logic/rom_wr_if.sv
logic/rom_prom.sv
logic/rom_downloader.sv
logic/rom_verify.sv
logic/rom_load_top.sv
verif/rom_load_checker.sv
verif/rom_load_tb.sv

//--- Makefile
# Verilator build and run for the rom load path

VERILATOR ?= verilator
TOP       ?= rom_load_tb
FILELIST  ?= rom_load_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/rom_load_tb.sv
`timescale 1ns/1ps
`include "rom_defines.svh"

// directed testbench for the graphics rom load path
module rom_load_tb;

    localparam int depth   = `ROM_DEPTH;
    localparam int n_basic = 200;           // plain download that is also read back
    localparam int n_gaps  = 150;           // download with idle cycles
    localparam int n_over  = depth + 24;    // runs past the prom size
    // worst case length of each test in cycles
    // gaps add up to 3 idle cycles per byte
    localparam int len_total = 4 + (2 * n_basic + 20) + (n_basic + 4) + (5 * n_gaps + 20)
                             + (n_over + depth + 40) + 40;
    localparam int cycle_limit = 4 * len_total;

    logic               clk;
    logic               arst_n;
    logic               dl_start;
    logic               dl_valid;
    logic [`ROM_DW-1:0] dl_data;
    logic               dl_end;
    logic               rd_cen;
    logic [`ROM_AW-1:0] rd_addr;
    logic [`ROM_DW-1:0] rd_q;
    logic               busy;
    logic               verify_done;
    logic               verify_ok;
    logic               overflow;

    logic [`ROM_DW-1:0] ref_mem [0:depth-1];   // expected prom contents
    rom_pkg::csum_t     ref_sum;                // expected byte sum
    int                 ref_count;              // bytes the prom should hold
    integer             seed = 23;
    int                 errors = 0;
    int                 checks = 0;
    int                 cycles = 0;

    rom_load_top u_dut (
        .clk(clk), .arst_n(arst_n),
        .dl_start(dl_start), .dl_valid(dl_valid), .dl_data(dl_data), .dl_end(dl_end),
        .rd_cen(rd_cen), .rd_addr(rd_addr), .rd_q(rd_q),
        .busy(busy), .verify_done(verify_done), .verify_ok(verify_ok), .overflow(overflow)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk; // 8 ns period

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic step(); // inputs change 1 ns after the edge
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // one download where the model keeps only bytes that fit in the prom
    task automatic download(input int n, input bit gaps);
        int                 i;
        int                 g;
        logic [`ROM_DW-1:0] b;
        step();
        dl_start = 1'b1;
        step();
        dl_start  = 1'b0;
        ref_count = 0;
        ref_sum   = '0;
        for (i = 0; i < n; i++) begin
            if (gaps) begin
                g = $random(seed) & 3;
                repeat (g) begin
                    dl_valid = 1'b0;
                    step();
                end
            end
            b        = $random(seed);
            dl_valid = 1'b1;
            dl_data  = b;
            if (ref_count < depth) begin
                ref_mem[ref_count] = b;
                ref_sum            = ref_sum + b;
                ref_count++;
            end
            step();
        end
        dl_valid = 1'b0;
        dl_end   = 1'b1;
        step(); // load_done cycle from here
        dl_end = 1'b0;
    endtask

    // counts edges from the load_done cycle to verify_done
    task automatic wait_verify(input int exp_cycles);
        int n;
        bit done;
        n    = 0;
        done = 1'b0;
        while (!done && n <= exp_cycles + 16) begin
            step();
            n++;
            if (verify_done) done = 1'b1;
        end
        if (!done) begin
            errors++;
            $display("verify_done never pulsed within %0d cycles of load_done", n);
        end else begin
            check_val("cycles to verify_done", n, exp_cycles);
            check_val("verify_ok", verify_ok, 1);
            check_val("verify sum", u_dut.csum, ref_sum);
        end
        step();
        check_val("busy after verify", busy, 0);
        check_val("verify_ok held", verify_ok, 1);
    endtask

    // back to back game reads with data checked the cycle after each read
    task automatic read_back(input int first, input int num);
        int a;
        for (a = first; a < first + num; a++) begin
            rd_cen  = 1'b1;
            rd_addr = a[`ROM_AW-1:0];
            step();
            check_val($sformatf("rd_q @%0d", a), rd_q, ref_mem[a]);
        end
        rd_cen = 1'b0;
    endtask

    task automatic test_reset();
        check_val("busy", busy, 0);
        check_val("verify_done", verify_done, 0);
        check_val("verify_ok", verify_ok, 0);
        check_val("overflow", overflow, 0);
        check_val("rd_q", rd_q, 0);
    endtask

    task automatic test_busy_reads();
        logic [`ROM_DW-1:0] held;
        int                 i;
        read_back(7, 1);
        held = rd_q;
        step();
        dl_start = 1'b1; // empty download
        step();
        dl_start = 1'b0;
        check_val("busy in download", busy, 1);
        check_val("overflow cleared", overflow, 0);
        for (i = 0; i < 4; i++) begin
            rd_cen  = 1'b1;
            rd_addr = 100 + i;
            step();
            check_val("rd_q while busy", rd_q, held);
        end
        rd_cen = 1'b0;
        check_val("verify_ok cleared", verify_ok, 0);
        dl_end = 1'b1;
        step();
        dl_end    = 1'b0;
        ref_count = 0;
        ref_sum   = '0;
        wait_verify(2);
    endtask

    initial begin
        arst_n   = 1'b0;
        dl_start = 1'b0;
        dl_valid = 1'b0;
        dl_data  = '0;
        dl_end   = 1'b0;
        rd_cen   = 1'b0;
        rd_addr  = '0;
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;

        test_reset();
        download(n_basic, 1'b0);        // full rate
        wait_verify(ref_count + 3);
        read_back(0, n_basic);
        download(n_gaps, 1'b1);         // idle cycles between bytes
        wait_verify(ref_count + 3);
        read_back(0, n_gaps);
        download(n_over, 1'b0);         // past the depth
        check_val("overflow", overflow, 1);
        wait_verify(depth + 3);
        read_back(0, 8);
        read_back(depth - 8, 8);
        test_busy_reads();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verif/rom_load_checker.sv
`timescale 1ns/1ps

// protocol checks on the rom load path
module rom_load_checker (
    input logic clk,
    input logic arst_n,
    input logic we,             // prom write strobe
    input logic downloading,
    input logic verify_done,
    input logic busy
);

    // prom writes only inside a download window
    a_we_in_download: assert property (@(posedge clk) disable iff (!arst_n)
        we |-> downloading)
        else $error("prom write strobe while no download is open");

    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        verify_done |=> !verify_done) // single cycle pulse
        else $error("verify_done held longer than one cycle");

    // game reads must be locked out during both phases and in the cycle between them
    a_busy_cover: assert property (@(posedge clk) disable iff (!arst_n)
        (verify_done || downloading || $fell(downloading)) |-> busy)
        else $error("busy low during a download or verify");

endmodule

bind rom_load_top rom_load_checker u_chk (
    .clk         (clk),
    .arst_n      (arst_n),
    .we          (wr_bus.we),
    .downloading (wr_bus.downloading),
    .verify_done (verify_done),
    .busy        (busy)
);

//--- logic/rom_load_top.sv
`timescale 1ns/1ps
`include "rom_defines.svh"

// graphics rom load path, downloader + verifier + prom
module rom_load_top (
    input  logic                clk,
    input  logic                arst_n,
    // download stream
    input  logic                dl_start,
    input  logic                dl_valid,
    input  logic [`ROM_DW-1:0]  dl_data,
    input  logic                dl_end,
    // game read port
    input  logic                rd_cen,
    input  logic [`ROM_AW-1:0]  rd_addr,
    output logic [`ROM_DW-1:0]  rd_q,
    // status
    output logic                busy,
    output logic                verify_done,
    output logic                verify_ok,
    output logic                overflow
);

    logic [`ROM_AW:0]    count;     // bytes stored by the downloader
    rom_pkg::csum_t      csum;      // their sum
    logic                load_done;
    logic                mem_cen;   // muxed prom read port
    logic [`ROM_AW-1:0]  mem_addr;
    logic [`ROM_DW-1:0]  q;

    rom_wr_if #(.dw(`ROM_DW), .aw(`ROM_AW)) wr_bus ();

    rom_downloader u_dl (
        .clk       (clk),
        .arst_n    (arst_n),
        .dl_start  (dl_start),
        .dl_valid  (dl_valid),
        .dl_data   (dl_data),
        .dl_end    (dl_end),
        .wr        (wr_bus.loader),
        .count     (count),
        .csum      (csum),
        .load_done (load_done),
        .overflow  (overflow)
    );

    rom_verify u_vf (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_done   (load_done),
        .count       (count),
        .csum        (csum),
        .wr          (wr_bus.mon),
        .ext_cen     (rd_cen),
        .ext_addr    (rd_addr),
        .mem_cen     (mem_cen),
        .mem_addr    (mem_addr),
        .q           (q),
        .rd_q        (rd_q),
        .busy        (busy),
        .verify_done (verify_done),
        .verify_ok   (verify_ok)
    );

    rom_prom #(.dw(`ROM_DW), .aw(`ROM_AW)) u_prom (
        .clk     (clk),
        .cen     (mem_cen),
        .rd_addr (mem_addr),
        .q       (q),
        .wr      (wr_bus.mem)
    );

endmodule

//--- logic/rom_verify.sv
`timescale 1ns/1ps
`include "rom_defines.svh"

// reads back the downloaded range, sums it and compares with the download sum
// owns the prom read port and lends it to the game while idle
module rom_verify (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                load_done,  // pulse from the downloader
    input  logic [`ROM_AW:0]    count,      // words to scan
    input  rom_pkg::csum_t      csum,       // expected sum
    rom_wr_if.mon               wr,
    input  logic                ext_cen,    // game read strobe
    input  logic [`ROM_AW-1:0]  ext_addr,
    output logic                mem_cen,    // prom read port
    output logic [`ROM_AW-1:0]  mem_addr,
    input  logic [`ROM_DW-1:0]  q,          // prom read data
    output logic [`ROM_DW-1:0]  rd_q,       // game read data
    output logic                busy,
    output logic                verify_done,
    output logic                verify_ok
);

    rom_pkg::vf_state_e  state;
    logic [`ROM_AW:0]    scan_cnt;  // next address to read, one bit wider than the prom
    logic [`ROM_AW:0]    scan_nxt;
    logic                scan_rd;   // scan read issued this cycle
    logic                ext_rd;    // game read accepted this cycle
    logic                scan_tag;  // q now holds a scanned word
    logic                ext_tag;   // q now holds a game word
    rom_pkg::csum_t      sum;       // read-back sum
    logic [`ROM_DW-1:0]  q_hold;    // last game word, kept while the scan moves q

    assign scan_rd  = (state == rom_pkg::VF_SCAN);
    assign scan_nxt = scan_cnt + 1'b1;

    // load_done is included so the cycle between dl_end and the scan is covered
    assign busy   = wr.downloading || load_done || (state != rom_pkg::VF_IDLE);
    assign ext_rd = ext_cen && !busy; // game reads while busy are dropped

    // read port mux, the scan has it whenever it runs
    assign mem_cen  = scan_rd || ext_rd;
    assign mem_addr = scan_rd ? scan_cnt[`ROM_AW-1:0] : ext_addr;

    assign verify_done = (state == rom_pkg::VF_DONE);

    // game data straight from the prom the cycle after the read, held otherwise
    assign rd_q = ext_tag ? q : q_hold;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= rom_pkg::VF_IDLE;
            scan_cnt  <= '0;
            scan_tag  <= 1'b0;
            ext_tag   <= 1'b0;
            sum       <= '0;
            q_hold    <= '0;
            verify_ok <= 1'b0;
        end else begin
            scan_tag <= scan_rd && !wr.downloading; // no tag for a read cut off by an abort
            ext_tag  <= ext_rd;

            if (ext_tag) q_hold <= q;
            if (scan_tag) sum <= sum + q; // prom latency already paid

            if (wr.downloading) begin
                // a new download invalidates both the scan and the old result
                state     <= rom_pkg::VF_IDLE;
                verify_ok <= 1'b0;
            end else begin
                case (state)
                    rom_pkg::VF_IDLE: begin
                        if (load_done) begin
                            sum      <= '0;
                            scan_cnt <= '0;
                            // empty download skips straight to the compare
                            state <= (count == '0) ? rom_pkg::VF_DRAIN : rom_pkg::VF_SCAN;
                        end
                    end
                    rom_pkg::VF_SCAN: begin
                        scan_cnt <= scan_nxt;
                        if (scan_nxt == count) state <= rom_pkg::VF_DRAIN; // last read issued
                    end
                    rom_pkg::VF_DRAIN: begin
                        if (!scan_tag) begin // sum has taken the last word
                            verify_ok <= (sum == csum);
                            state     <= rom_pkg::VF_DONE;
                        end
                    end
                    default: state <= rom_pkg::VF_IDLE; // VF_DONE lasts one cycle
                endcase
            end
        end
    end

endmodule

//--- logic/rom_downloader.sv
`timescale 1ns/1ps
`include "rom_defines.svh"

// byte stream to sequential prom writes
// also keeps the byte count and running checksum for the verifier
module rom_downloader (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                dl_start,   // pulse, opens a download
    input  logic                dl_valid,   // one byte on dl_data
    input  logic [`ROM_DW-1:0]  dl_data,
    input  logic                dl_end,     // pulse, closes the download
    rom_wr_if.loader            wr,
    output logic [`ROM_AW:0]    count,      // bytes stored so far
    output rom_pkg::csum_t      csum,       // sum of stored bytes
    output logic                load_done,  // one cycle after dl_end edge
    output logic                overflow    // bytes were dropped past the depth
);

    localparam logic [`ROM_AW:0] full_cnt = `ROM_DEPTH; // count at which the prom is full

    rom_pkg::dl_state_e state;
    logic               full;   // no room left
    logic               take;   // byte accepted this cycle
    logic               drop;   // byte refused, prom full

    assign full = (count == full_cnt);

    // dl_start and dl_end win over a byte in the same cycle
    // a byte taken with dl_end would be written after downloading fell
    assign take = (state == rom_pkg::DL_LOAD) && dl_valid && !dl_end && !dl_start && !full;
    assign drop = (state == rom_pkg::DL_LOAD) && dl_valid && !dl_end && !dl_start && full;

    assign wr.downloading = (state == rom_pkg::DL_LOAD);
    assign load_done      = (state == rom_pkg::DL_DONE); // state lasts one cycle

    // control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= rom_pkg::DL_IDLE;
            count    <= '0;
            csum     <= '0;
            overflow <= 1'b0;
            wr.we    <= 1'b0;
        end else begin
            wr.we <= take; // write lands one cycle after the byte

            if (take) begin
                count <= count + 1'b1;
                csum  <= csum + dl_data; // wraps mod 256
            end
            if (drop) begin
                overflow <= 1'b1; // sticky until the next download
            end

            if (dl_start) begin
                // restart from any state, a late dl_start also restarts a running load
                state    <= rom_pkg::DL_LOAD;
                count    <= '0;
                csum     <= '0;
                overflow <= 1'b0;
            end else begin
                case (state)
                    rom_pkg::DL_LOAD: begin
                        if (dl_end) state <= rom_pkg::DL_DONE;
                    end
                    rom_pkg::DL_DONE: state <= rom_pkg::DL_IDLE;
                    default:          state <= rom_pkg::DL_IDLE; // idle waits for dl_start
                endcase
            end
        end
    end

    // write payload, address is the number of bytes taken before this one
    always_ff @(posedge clk) begin
        if (take) begin
            wr.addr <= count[`ROM_AW-1:0];
            wr.data <= dl_data;
        end
    end

endmodule

//--- logic/rom_prom.sv
`timescale 1ns/1ps

// synchronous prom with separate read and write addresses
// read side follows the game clock enable, write side runs every clock
module rom_prom #(
    parameter int dw = 8,   // word width
    parameter int aw = 10   // address width, depth is 2**aw
) (
    input  logic          clk,
    input  logic          cen,      // read enable
    input  logic [aw-1:0] rd_addr,
    output logic [dw-1:0] q,        // registered read data
    rom_wr_if.mem         wr        // download write port
);

    // contents come only from the download, never reset
    logic [dw-1:0] mem [0:(2**aw)-1];

    // read port, q holds between enables
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr]; // one cycle latency
        end
    end

    // write port ignores cen
    // the byte stream arrives at full rate and must never be stalled
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // a read and a write to the same address in one cycle return the old word

endmodule

//--- logic/rom_wr_if.sv
`timescale 1ns/1ps
`include "rom_defines.svh"

// download write port, loader to prom
interface rom_wr_if #(
    parameter int dw = `ROM_DW,
    parameter int aw = `ROM_AW
) ();

    logic [aw-1:0] addr;    // write address, sequential during a download
    logic [dw-1:0] data;    // byte to store
    logic          we;      // write strobe, one per accepted byte
    logic          downloading; // high from dl_start+1 to dl_end+1

    // the downloader owns everything on the bus
    modport loader (output addr, output data, output we, output downloading);

    // prom side only needs the write triple
    modport mem (input addr, input data, input we);

    // verifier watches for a new download so it can abort its scan
    modport mon (input downloading);

endinterface

//--- logic/rom_pkg.sv
package rom_pkg;

    // downloader sequencing
    typedef enum logic [1:0] {
        DL_IDLE = 2'd0, // waiting for dl_start
        DL_LOAD = 2'd1, // bytes are accepted, downloading is high
        DL_DONE = 2'd2  // single cycle, load_done pulse
    } dl_state_e;

    // read-back verifier sequencing
    typedef enum logic [1:0] {
        VF_IDLE  = 2'd0, // read port belongs to the game
        VF_SCAN  = 2'd1, // one read per cycle over 0..count-1
        VF_DRAIN = 2'd2, // last words still in flight through the prom
        VF_DONE  = 2'd3  // compare result out, verify_done pulse
    } vf_state_e;

    // byte sum modulo 256
    typedef logic [7:0] csum_t;

endpackage

//--- include/rom_defines.svh
`ifndef ROM_DEFINES_SVH
`define ROM_DEFINES_SVH

// graphics rom geometry shared by the load path

// one byte per prom word
`define ROM_DW 8

// address bits of the prom, 1k words
`define ROM_AW 10

// number of words the download can fill
// the byte counter is one bit wider so it can hold this value
`define ROM_DEPTH (1 << `ROM_AW)

`endif
